//--- Makefile
# Verilator flow for the cartridge loader testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_cart_loader
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing -Wall
SIM_FLAGS  ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/cart_loader_top.sv
// Top level of the cartridge loading front end.
// Connects the configuration and reset block, the header detector, the
// work RAM clear and the cheat record assembler. FILL_ADDR_W sets the
// size of the work RAM that is filled after each cartridge download.
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int FILL_ADDR_W = 17
) (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	// Host configuration bus
	input  logic                                   cfg_wr,
	input  logic                                   cfg_addr,
	input  logic [7:0]                             cfg_wdata,
	output logic [7:0]                             cfg_rdata,
	// Download stream
	input  logic                                   dl_active,
	input  logic [7:0]                             dl_index,
	input  logic                                   dl_wr,
	input  logic [snes_load_pkg::DL_ADDR_W-1:0]    dl_addr,
	input  logic [snes_load_pkg::DL_DATA_W-1:0]    dl_data,
	// Cartridge description
	output logic [7:0]                             rom_type,
	output logic [snes_load_pkg::MASK_W-1:0]       rom_mask,
	output logic [snes_load_pkg::MASK_W-1:0]       ram_mask,
	output logic                                   pal,
	// Work RAM fill port
	output logic                                   clearing,
	output logic                                   fill_we,
	output logic [FILL_ADDR_W-1:0]                 fill_addr,
	output logic [7:0]                             fill_data,
	// Cheat records
	output logic [snes_load_pkg::CODE_W-1:0]       cheat_code,
	output logic                                   cheat_valid,
	output logic                                   cheat_reset,
	output logic                                   cheat_enable,
	output logic                                   core_reset
);
	import snes_load_pkg::*;

	logic         cart_loading;
	logic         code_loading;
	logic         cart_start;
	header_mode_e header_mode;
	logic [1:0]   region_mode;
	logic [1:0]   fill_pattern;

	load_control load_control_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.clearing     (clearing),
		.cart_loading (cart_loading),
		.code_loading (code_loading),
		.cart_start   (cart_start),
		.header_mode  (header_mode),
		.region_mode  (region_mode),
		.fill_pattern (fill_pattern),
		.cheat_enable (cheat_enable),
		.core_reset   (core_reset)
	);

	header_detect header_detect_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_loading (cart_loading),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.header_mode  (header_mode),
		.region_mode  (region_mode),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal)
	);

	ram_clear #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) ram_clear_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_start   (cart_start),
		.fill_pattern (fill_pattern),
		.clearing     (clearing),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	cheat_assembler cheat_assembler_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_loading (code_loading),
		.cart_loading (cart_loading),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cheat_code   (cheat_code),
		.cheat_valid  (cheat_valid),
		.cheat_reset  (cheat_reset)
	);

endmodule

`default_nettype wire

//--- source/cheat_assembler.sv
// Cheat record assembly from code downloads.
// Each record arrives as eight 16-bit words placed by address offset.
// The replace high word completes a record and raises cheat_valid for
// one cycle. cheat_reset tells the cheat engine to drop its table.
`timescale 1ns/1ps
`default_nettype none

module cheat_assembler (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                code_loading,
	input  logic                                cart_loading,
	input  logic                                dl_wr,
	input  logic [snes_load_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [snes_load_pkg::DL_DATA_W-1:0] dl_data,
	output logic [snes_load_pkg::CODE_W-1:0]    cheat_code,
	output logic                                cheat_valid,
	output logic                                cheat_reset
);
	import snes_load_pkg::*;

	logic code_wr;

	assign code_wr = code_loading && dl_wr;

	// ==================================================
	// Record layout: flags, address, compare, replace
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= dl_data;
				4'd2:  cheat_code[127:112] <= dl_data;
				4'd4:  cheat_code[79:64]   <= dl_data;
				4'd6:  cheat_code[95:80]   <= dl_data;
				4'd8:  cheat_code[47:32]   <= dl_data;
				4'd10: cheat_code[63:48]   <= dl_data;
				4'd12: cheat_code[15:0]    <= dl_data;
				4'd14: cheat_code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl_addr[3:0] == 4'd14);
			// New code file or new cartridge clears the table
			cheat_reset <= cart_loading || (code_wr && (dl_addr == '0));
		end
	end

endmodule

`default_nettype wire

//--- source/header_detect.sv
// Cartridge description from the downloaded ROM image.
// Picks mapper type, ROM mask and save RAM mask from either the copier
// header word or the internal header, as the header mode selects, and
// sets the video region from the header flag or a forced choice.
`timescale 1ns/1ps
`default_nettype none

module header_detect (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  logic                               cart_loading,
	input  logic                               dl_wr,
	input  logic [snes_load_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [snes_load_pkg::DL_DATA_W-1:0] dl_data,
	input  snes_load_pkg::header_mode_e        header_mode,
	input  logic [1:0]                         region_mode,
	output logic [7:0]                         rom_type,
	output logic [snes_load_pkg::MASK_W-1:0]   rom_mask,
	output logic [snes_load_pkg::MASK_W-1:0]   ram_mask,
	output logic                               pal
);
	import snes_load_pkg::*;

	dl_word_u             dl_word;
	logic                 hdr_wr;
	logic                 hdr_forced;
	logic [DL_ADDR_W-1:0] hdr_base;
	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic [3:0]           rom_size_nx;
	logic [3:0]           ram_size_nx;
	logic [7:0]           type_nx;
	logic                 rom_region;

	// 1 KiB scaled by the header size code
	function automatic logic [MASK_W-1:0] size_mask(input logic [3:0] size);
		size_mask = (MASK_W'(1024) << size) - MASK_W'(1);
	endfunction

	assign dl_word = dl_data;
	assign hdr_wr  = cart_loading && dl_wr;

	// Internal header base for the forced mapper modes
	always_comb begin
		hdr_forced = 1'b1;
		hdr_base   = HDR_LOROM_OFS;
		case (header_mode)
			HDR_LOROM:   hdr_base = HDR_LOROM_OFS;
			HDR_HIROM:   hdr_base = HDR_HIROM_OFS;
			HDR_EXHIROM: hdr_base = HDR_EXHIROM_OFS;
			default:     hdr_forced = 1'b0;
		endcase
	end

	// ==================================================
	// Next sizes and type for the current write
	// ==================================================
	always_comb begin
		rom_size_nx = rom_size;
		ram_size_nx = ram_size;
		if (dl_addr == '0) begin
			rom_size_nx = 4'hC;
			ram_size_nx = 4'h0;
			if (header_mode == HDR_AUTO && dl_word.raw[7:0] != 8'h00) begin
				rom_size_nx = dl_word.hdr.rom_size;
				ram_size_nx = dl_word.hdr.ram_size;
			end
		end
		if (hdr_forced) begin
			if (dl_addr == hdr_base + COPIER_OFS)
				rom_size_nx = dl_word.raw[11:8];
			// RAM size byte sits two bytes above the base
			if (dl_addr == hdr_base + COPIER_OFS + DL_ADDR_W'(2))
				ram_size_nx = dl_word.raw[3:0];
		end
	end

	always_comb begin
		case (header_mode)
			HDR_NONE:    type_nx = 8'd0;
			HDR_LOROM:   type_nx = 8'd0;
			HDR_HIROM:   type_nx = 8'd1;
			HDR_EXHIROM: type_nx = 8'd2;
			default:     type_nx = dl_word.hdr.map_type;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'h0;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_mask   <= '0;
			ram_mask   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (hdr_wr) begin
				rom_size <= rom_size_nx;
				ram_size <= ram_size_nx;
				rom_mask <= size_mask(rom_size_nx);
				ram_mask <= (ram_size_nx == 4'h0) ? '0 : size_mask(ram_size_nx);
				if (dl_addr == '0)
					rom_type <= type_nx;
				if (dl_addr == DL_ADDR_W'(2))
					rom_region <= dl_word.raw[8];
			end
			// Region follows the header only between downloads
			if (!cart_loading)
				pal <= (region_mode == 2'd0) ? rom_region : region_mode[1];
		end
	end

endmodule

`default_nettype wire

//--- source/load_control.sv
// Host configuration registers and download decoding.
// Register 0 holds header mode and cheat enable, register 1 holds the
// region mode and fill pattern. Also classifies the download stream
// and keeps the console core in reset while a cartridge loads.
`timescale 1ns/1ps
`default_nettype none

module load_control (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        cfg_wr,
	input  logic                        cfg_addr,
	input  logic [7:0]                  cfg_wdata,
	output logic [7:0]                  cfg_rdata,
	input  logic                        dl_active,
	input  logic [7:0]                  dl_index,
	input  logic                        clearing,
	output logic                        cart_loading,
	output logic                        code_loading,
	output logic                        cart_start,
	output snes_load_pkg::header_mode_e header_mode,
	output logic [1:0]                  region_mode,
	output logic [1:0]                  fill_pattern,
	output logic                        cheat_enable,
	output logic                        core_reset
);
	import snes_load_pkg::*;

	logic [3:0] cfg_reg0;
	logic [3:0] cfg_reg1;
	logic       cart_loading_q;

	// ==================================================
	// Configuration registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cfg_reg0 <= 4'h0;
			cfg_reg1 <= 4'h0;
		end else if (cfg_wr) begin
			if (cfg_addr) begin
				cfg_reg1 <= cfg_wdata[3:0];
			end else if (!cart_loading) begin
				// Header mode is frozen while a cartridge streams in
				cfg_reg0 <= cfg_wdata[3:0];
			end
		end
	end

	assign cfg_rdata = cfg_addr ? {4'h0, cfg_reg1} : {4'h0, cfg_reg0};

	assign header_mode  = header_mode_e'(cfg_reg0[2:0]);
	assign cheat_enable = cfg_reg0[3];
	assign region_mode  = cfg_reg1[1:0];
	assign fill_pattern = cfg_reg1[3:2];

	// ==================================================
	// Download kind and core reset
	// ==================================================
	assign cart_loading = dl_active && (dl_index[5:0] == IDX_CART);
	assign code_loading = dl_active && (dl_index == IDX_CODE);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_loading_q <= 1'b0;
			cart_start     <= 1'b0;
			core_reset     <= 1'b1;
		end else begin
			cart_loading_q <= cart_loading;
			// Single pulse on the first cycle of a cartridge download
			cart_start     <= cart_loading && !cart_loading_q;
			core_reset     <= cart_loading || clearing;
		end
	end

endmodule

`default_nettype wire

//--- source/ram_clear.sv
// Work RAM clear after a cartridge download starts.
// Walks every work RAM address once, one byte per cycle, and writes
// the start-up pattern chosen by the host. clearing stays high for the
// whole sweep and keeps the core in reset.
`timescale 1ns/1ps
`default_nettype none

module ram_clear #(
	parameter int FILL_ADDR_W = 17
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_start,
	input  logic [1:0]             fill_pattern,
	output logic                   clearing,
	output logic                   fill_we,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]             fill_data
);
	import snes_load_pkg::*;

	// ==================================================
	// Address sweep
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (cart_start)
				clearing <= 1'b1;
			else if (clearing && (&fill_addr))
				clearing <= 1'b0;

			if (clearing)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	assign fill_we = clearing;

	// Pattern selection, as seen on different console revisions
	always_comb begin
		case (fill_pattern)
			FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = 8'h55;
			FILL_FF:   fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- source/snes_load_pkg.sv
// Shared definitions for the cartridge loading front end.
// Every loader module imports this package for the download bus widths,
// the index codes, the internal header locations, the work RAM fill
// pattern codes and the two views of a download data word.
`default_nettype none

package snes_load_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;
	localparam int MASK_W    = 24;
	localparam int CODE_W    = 128;

	// Download index codes
	// Cartridge files use the low six index bits only
	localparam logic [5:0] IDX_CART = 6'h00;
	localparam logic [7:0] IDX_CODE = 8'hFF;

	// ==================================================
	// Header locations
	// ==================================================
	localparam logic [DL_ADDR_W-1:0] COPIER_OFS      = 25'h000200;
	localparam logic [DL_ADDR_W-1:0] HDR_LOROM_OFS   = 25'h007FD6;
	localparam logic [DL_ADDR_W-1:0] HDR_HIROM_OFS   = 25'h00FFD6;
	localparam logic [DL_ADDR_W-1:0] HDR_EXHIROM_OFS = 25'h40FFD6;

	// Header interpretation selected by the host
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	// Start-up work RAM patterns
	localparam logic [1:0] FILL_9966 = 2'd0;
	localparam logic [1:0] FILL_00FF = 2'd1;
	localparam logic [1:0] FILL_55   = 2'd2;
	localparam logic [1:0] FILL_FF   = 2'd3;

	// ==================================================
	// Download data word
	// ==================================================
	// Copier header word 0 carries mapper type and both sizes
	typedef union packed {
		logic [DL_DATA_W-1:0] raw;
		struct packed {
			logic [7:0] map_type;
			logic [3:0] ram_size;
			logic [3:0] rom_size;
		} hdr;
	} dl_word_u;

endpackage

`default_nettype wire

//--- tb/load_checker.sv
// Reference model and comparator for the cartridge loader testbench.
// Samples DUT inputs and outputs on the falling clock edge, compares the
// outputs with its model, and prints one line per finished test and a
// closing count line. error_count goes back to the testbench top.
`timescale 1ns/1ps
`default_nettype none

module load_checker #(
	parameter int FILL_ADDR_W = 10
) (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                cfg_wr,
	input  logic                                cfg_addr,
	input  logic [7:0]                          cfg_wdata,
	input  logic [7:0]                          cfg_rdata,
	input  logic                                dl_active,
	input  logic [7:0]                          dl_index,
	input  logic                                dl_wr,
	input  logic [snes_load_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [snes_load_pkg::DL_DATA_W-1:0] dl_data,
	input  logic [7:0]                          rom_type,
	input  logic [snes_load_pkg::MASK_W-1:0]    rom_mask,
	input  logic [snes_load_pkg::MASK_W-1:0]    ram_mask,
	input  logic                                pal,
	input  logic                                clearing,
	input  logic                                fill_we,
	input  logic [FILL_ADDR_W-1:0]              fill_addr,
	input  logic [7:0]                          fill_data,
	input  logic [snes_load_pkg::CODE_W-1:0]    cheat_code,
	input  logic                                cheat_valid,
	input  logic                                cheat_reset,
	input  logic                                cheat_enable,
	input  logic                                core_reset,
	input  logic [2:0]                          test_id,
	input  logic                                test_end,
	input  logic                                run_done,
	output int                                  error_count
);
	import snes_load_pkg::*;

	localparam int FILL_WORDS = 1 << FILL_ADDR_W;

	logic [3:0]        m_reg0;
	logic [3:0]        m_reg1;
	logic              m_cart_q;
	logic              m_start;
	logic              m_core_reset;
	logic [3:0]        m_rom_sz;
	logic [3:0]        m_ram_sz;
	logic [7:0]        m_type;
	logic [MASK_W-1:0] m_rom_mask;
	logic [MASK_W-1:0] m_ram_mask;
	logic              m_region;
	logic              m_pal;
	logic              m_clearing;
	int                m_faddr;
	logic              m_valid;
	logic              m_creset;
	logic [CODE_W-1:0] m_code;
	logic              model_live;
	int                fill_seen;
	int                check_count;
	int                test_checks;
	int                test_errors;
	int                tests_done;

	initial begin
		model_live  = 1'b0;
		error_count = 0;
		fill_seen   = 0;
		check_count = 0;
		test_checks = 0;
		test_errors = 0;
		tests_done  = 0;
	end

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0:    test_name = "auto_header";
			3'd1:    test_name = "forced_mapper";
			3'd2:    test_name = "region";
			3'd3:    test_name = "ram_clear";
			3'd4:    test_name = "cheat_assembly";
			default: test_name = "config_regs";
		endcase
	endfunction

	// Ones below bit 10 plus size
	function automatic logic [MASK_W-1:0] mask_of(input logic [3:0] sz);
		mask_of = ~({MASK_W{1'b1}} << (10 + int'(sz)));
	endfunction

	function automatic logic [7:0] fill_of(input int addr, input logic [1:0] pat);
		logic [9:0] a;
		a = addr[9:0];
		case (pat)
			2'd0:    fill_of = (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1:    fill_of = (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2:    fill_of = 8'h55;
			default: fill_of = 8'hFF;
		endcase
	endfunction

	task automatic compare(input string what, input logic [CODE_W-1:0] expected,
			input logic [CODE_W-1:0] actual);
		check_count++;
		test_checks++;
		if (actual !== expected) begin
			error_count++;
			test_errors++;
			$display("ERROR %s %s: expected %0h, actual %0h",
				test_name(test_id), what, expected, actual);
		end
	endtask

	// ==================================================
	// Output comparison against the model state
	// ==================================================
	task automatic compare_outputs();
		compare("cfg_rdata", {4'h0, cfg_addr ? m_reg1 : m_reg0}, cfg_rdata);
		compare("cheat_enable", m_reg0[3], cheat_enable);
		compare("rom_type", m_type, rom_type);
		compare("rom_mask", m_rom_mask, rom_mask);
		compare("ram_mask", m_ram_mask, ram_mask);
		compare("pal", m_pal, pal);
		compare("clearing", m_clearing, clearing);
		compare("fill_we", m_clearing, fill_we);
		compare("core_reset", m_core_reset, core_reset);
		compare("cheat_valid", m_valid, cheat_valid);
		compare("cheat_reset", m_creset, cheat_reset);
		if (m_clearing) begin
			compare("fill_addr", CODE_W'(m_faddr), fill_addr);
			compare("fill_data", fill_of(m_faddr, m_reg1[3:2]), fill_data);
		end
		if (m_valid)
			compare("cheat_code", m_code, cheat_code);
		if (fill_we)
			fill_seen++;
	endtask

	// ==================================================
	// Model step for the next rising edge
	// ==================================================
	task automatic advance_model();
		logic                 cart;
		logic                 code_wr;
		logic                 next_clearing;
		logic [2:0]           mode;
		logic [DL_ADDR_W-1:0] base;
		logic [3:0]           rs;
		logic [3:0]           ras;
		if (RESET) begin
			m_reg0       = 4'h0;
			m_reg1       = 4'h0;
			m_cart_q     = 1'b0;
			m_start      = 1'b0;
			m_core_reset = 1'b1;
			m_rom_sz     = 4'h0;
			m_ram_sz     = 4'h0;
			m_type       = 8'h00;
			m_rom_mask   = '0;
			m_ram_mask   = '0;
			m_region     = 1'b0;
			m_pal        = 1'b0;
			m_clearing   = 1'b0;
			m_faddr      = 0;
			m_valid      = 1'b0;
			m_creset     = 1'b0;
			fill_seen    = 0;
			model_live   = 1'b1;
		end else begin
			cart    = dl_active && (dl_index[5:0] == 6'd0);
			code_wr = dl_active && (dl_index == 8'hFF) && dl_wr;
			mode    = m_reg0[2:0];

			// Region output only moves between downloads
			if (!cart)
				m_pal = (m_reg1[1:0] == 2'd0) ? m_region : m_reg1[1];
			m_core_reset = cart || m_clearing;

			next_clearing = m_start || (m_clearing && m_faddr != FILL_WORDS - 1);
			if (m_clearing && !next_clearing) begin
				compare("fill write count", CODE_W'(FILL_WORDS), CODE_W'(fill_seen));
				fill_seen = 0;
			end
			m_faddr    = m_clearing ? (m_faddr + 1) % FILL_WORDS : 0;
			m_clearing = next_clearing;
			m_start    = cart && !m_cart_q;
			m_cart_q   = cart;

			if (cart && dl_wr) begin
				rs   = m_rom_sz;
				ras  = m_ram_sz;
				base = (mode == 3'd3) ? HDR_HIROM_OFS :
					(mode == 3'd4) ? HDR_EXHIROM_OFS : HDR_LOROM_OFS;
				if (dl_addr == '0) begin
					rs  = 4'hC;
					ras = 4'h0;
					if (mode == 3'd0 && dl_data[7:0] != 8'h00) begin
						rs  = dl_data[3:0];
						ras = dl_data[7:4];
					end
					case (mode)
						3'd1, 3'd2: m_type = 8'd0;
						3'd3:       m_type = 8'd1;
						3'd4:       m_type = 8'd2;
						default:    m_type = dl_data[15:8];
					endcase
				end
				if (mode >= 3'd2 && mode <= 3'd4) begin
					if (dl_addr == base + 25'h200)
						rs = dl_data[11:8];
					if (dl_addr == base + 25'h202)
						ras = dl_data[3:0];
				end
				if (dl_addr == 25'd2)
					m_region = dl_data[8];
				m_rom_sz   = rs;
				m_ram_sz   = ras;
				m_rom_mask = mask_of(rs);
				m_ram_mask = (ras == 4'h0) ? '0 : mask_of(ras);
			end

			m_valid  = code_wr && (dl_addr[3:0] == 4'd14);
			m_creset = cart || (code_wr && dl_addr == '0);
			if (code_wr) begin
				case (dl_addr[3:0])
					4'd0:    m_code[111:96]  = dl_data;
					4'd2:    m_code[127:112] = dl_data;
					4'd4:    m_code[79:64]   = dl_data;
					4'd6:    m_code[95:80]   = dl_data;
					4'd8:    m_code[47:32]   = dl_data;
					4'd10:   m_code[63:48]   = dl_data;
					4'd12:   m_code[15:0]    = dl_data;
					4'd14:   m_code[31:16]   = dl_data;
					default: ;
				endcase
			end

			if (cfg_wr) begin
				if (cfg_addr)
					m_reg1 = cfg_wdata[3:0];
				else if (!cart)
					m_reg0 = cfg_wdata[3:0];
			end
		end
	endtask

	always @(negedge clk_sys) begin
		if (model_live)
			compare_outputs();
		advance_model();
		if (test_end) begin
			tests_done++;
			$display("Test %s finished: %0d checks, %0d errors",
				test_name(test_id), test_checks, test_errors);
			test_checks = 0;
			test_errors = 0;
		end
		if (run_done)
			$display("Summary: %0d tests, %0d checks, %0d errors",
				tests_done, check_count, error_count);
	end

endmodule

`default_nettype wire

//--- tb/tb_cart_loader.sv
// Testbench top for the cartridge loading front end.
// Drives host configuration writes and download streams with seeded random
// data. load_checker compares every DUT output with its own model, and
// this module prints the verdict from the checker's error count.
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;
	import snes_load_pkg::*;

	localparam int FILL_ADDR_W = 10;
	localparam int FILL_WORDS  = 1 << FILL_ADDR_W;

	logic                   clk_sys;
	logic                   RESET;
	logic                   cfg_wr;
	logic                   cfg_addr;
	logic [7:0]             cfg_wdata;
	logic [7:0]             cfg_rdata;
	logic                   dl_active;
	logic [7:0]             dl_index;
	logic                   dl_wr;
	logic [DL_ADDR_W-1:0]   dl_addr;
	logic [DL_DATA_W-1:0]   dl_data;
	logic [7:0]             rom_type;
	logic [MASK_W-1:0]      rom_mask;
	logic [MASK_W-1:0]      ram_mask;
	logic                   pal;
	logic                   clearing;
	logic                   fill_we;
	logic [FILL_ADDR_W-1:0] fill_addr;
	logic [7:0]             fill_data;
	logic [CODE_W-1:0]      cheat_code;
	logic                   cheat_valid;
	logic                   cheat_reset;
	logic                   cheat_enable;
	logic                   core_reset;
	logic [2:0]             test_id;
	logic                   test_end;
	logic                   run_done;
	int                     error_count;
	int                     seed;

	cart_loader_top #(.FILL_ADDR_W(FILL_ADDR_W)) cart_loader_top_inst (.*);

	load_checker #(.FILL_ADDR_W(FILL_ADDR_W)) load_checker_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Bus tasks
	// ==================================================
	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic cfg_write(input logic addr, input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk_sys);
		cfg_wr    <= 1'b0;
	endtask

	task automatic dl_write(input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
	endtask

	task automatic dl_open(input logic [7:0] index);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= index;
	endtask

	task automatic dl_close();
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	task automatic wait_clear_start();
		int n;
		@(negedge clk_sys);
		for (n = 0; n < 8 && !clearing; n++)
			@(negedge clk_sys);
		if (!clearing)
			timeout_fail("the work RAM clear to start");
	endtask

	task automatic wait_core_release();
		int n;
		@(negedge clk_sys);
		for (n = 0; n < 4 * FILL_WORDS && (clearing || core_reset); n++)
			@(negedge clk_sys);
		if (clearing || core_reset)
			timeout_fail("the core reset to release");
	endtask

	task automatic wait_cheat_valid();
		int n;
		@(negedge clk_sys);
		for (n = 0; n < 4 && !cheat_valid; n++)
			@(negedge clk_sys);
		if (!cheat_valid)
			timeout_fail("a completed cheat record");
	endtask

	// Cartridge index with random upper bits
	task automatic cart_open();
		logic [15:0] r;
		r = 16'($random(seed));
		dl_open({r[1:0], 6'h00});
		wait_clear_start();
	endtask

	task automatic start_test(input logic [2:0] id);
		@(posedge clk_sys);
		test_id <= id;
	endtask

	task automatic end_test();
		@(posedge clk_sys);
		test_end <= 1'b1;
		@(posedge clk_sys);
		test_end <= 1'b0;
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int                   i;
		int                   j;
		int                   k;
		int                   tmp;
		int                   ofs [7];
		logic [15:0]          d;
		logic [DL_ADDR_W-1:0] base;
		logic [3:0]           last0;

		seed      = 32'h870a_0ea7;
		RESET     = 1'b1;
		cfg_wr    = 1'b0;
		cfg_addr  = 1'b0;
		cfg_wdata = 8'h00;
		dl_active = 1'b0;
		dl_index  = 8'h00;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		test_id   = 3'd0;
		test_end  = 1'b0;
		run_done  = 1'b0;
		repeat (4) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// Copier header word at address 0, some with an empty low byte
		start_test(3'd0);
		cfg_write(1'b0, 8'h00);
		for (k = 0; k < 2; k++) begin
			cart_open();
			for (i = 0; i < 10; i++) begin
				d = 16'($random(seed));
				if (i % 3 == 0)
					d[7:0] = 8'h00;
				dl_write('0, d);
			end
			dl_close();
			wait_core_release();
		end
		end_test();

		// No header, LoROM, HiROM and ExHiROM
		start_test(3'd1);
		for (k = 1; k <= 4; k++) begin
			for (j = 0; j < 2; j++) begin
				cfg_write(1'b0, 8'(k));
				if (k == 3)
					base = HDR_HIROM_OFS;
				else if (k == 4)
					base = HDR_EXHIROM_OFS;
				else
					base = HDR_LOROM_OFS;
				cart_open();
				dl_write('0, 16'($random(seed)));
				dl_write(base + COPIER_OFS, 16'($random(seed)));
				d = 16'($random(seed));
				if (j == 1)
					d[3:0] = 4'h0;
				dl_write(base + COPIER_OFS + DL_ADDR_W'(2), d);
				dl_close();
				wait_core_release();
			end
		end
		end_test();

		start_test(3'd2);
		cfg_write(1'b0, 8'h00);
		for (k = 0; k < 8; k++) begin
			d = 16'($random(seed));
			cfg_write(1'b1, {4'h0, d[1:0], 2'(k)});
			cart_open();
			dl_write(DL_ADDR_W'(2), 16'($random(seed)));
			dl_close();
			wait_core_release();
			repeat (2) @(posedge clk_sys);
		end
		end_test();

		start_test(3'd3);
		for (k = 0; k < 4; k++) begin
			d = 16'($random(seed));
			cfg_write(1'b1, {4'h0, 2'(k), d[1:0]});
			cart_open();
			dl_write('0, d);
			dl_close();
			wait_core_release();
		end
		end_test();

		// Three records, offset 14 always last
		start_test(3'd4);
		cfg_write(1'b0, 8'h08);
		dl_open(IDX_CODE);
		for (k = 0; k < 3; k++) begin
			for (i = 0; i < 7; i++)
				ofs[i] = 2 * i;
			for (i = 6; i > 0; i--) begin
				j = int'($unsigned($random(seed)) % (i + 1));
				tmp = ofs[i];
				ofs[i] = ofs[j];
				ofs[j] = tmp;
			end
			for (i = 0; i < 7; i++)
				dl_write(DL_ADDR_W'(k * 16 + ofs[i]), 16'($random(seed)));
			dl_write(DL_ADDR_W'(k * 16 + 14), 16'($random(seed)));
			wait_cheat_valid();
		end
		dl_close();
		end_test();

		start_test(3'd5);
		last0 = 4'h8;
		for (i = 0; i < 16; i++) begin
			d = 16'($random(seed));
			cfg_write(d[8], d[7:0]);
			if (!d[8])
				last0 = d[3:0];
			@(posedge clk_sys);
		end
		cart_open();
		// Locked write always differs from the held value
		d = 16'($random(seed));
		cfg_write(1'b0, {d[7:4], ~last0});
		dl_close();
		wait_core_release();
		end_test();

		@(posedge clk_sys);
		run_done <= 1'b1;
		@(posedge clk_sys);
		run_done <= 1'b0;
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/snes_load_pkg.sv
source/load_control.sv
source/header_detect.sv
source/ram_clear.sv
source/cheat_assembler.sv
source/cart_loader_top.sv
tb/load_checker.sv
tb/tb_cart_loader.sv
